/* verilog.f */
rtl/char_pkg.sv
rtl/input_sampler.sv
rtl/wall_detect.sv
rtl/char_fsm.sv
rtl/char_physics.sv
rtl/char_top.sv
test/char_assert.sv
test/char_tb.sv

/* run.sh */
#!/bin/sh
# build and run the character controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f verilog.f --top-module char_tb -o char_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/char_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

/* test/char_tb.sv */
`timescale 1ns/1ps

module char_tb;

    localparam int FLIGHT_TICKS = 101;     // landing wait limit plus the first tick
    localparam int PLAN_TICKS   = 33 + 17 + 57 + 13 + 300 + 4 * FLIGHT_TICKS;
    localparam int MAX_CYCLES   = 8 * PLAN_TICKS * 2;

    logic                  sys_clk;
    logic                  sys_rst_n;
    char_pkg::btn_t        btn;
    logic                  char_tick;
    char_pkg::kin_t        kin;
    char_pkg::char_state_e state;
    logic signed [1:0]     face;
    logic [15:0]           charge_level;

    // model copy of the character
    char_pkg::char_state_e m_state;
    logic signed [1:0]     m_face;
    int                    m_charge;
    int                    m_px, m_py, m_vx, m_vy;
    logic                  m_prev_ground;
    logic                  m_armed;
    logic                  m_bounced;
    char_pkg::btn_t        m_btn;

    logic [15:0] lfsr;
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          err_mark;
    int          cycles;
    int          tick_age;
    int          n;

    char_top dut (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .btn          (btn),
        .char_tick    (char_tick),
        .kin          (kin),
        .state        (state),
        .face         (face),
        .charge_level (charge_level)
    );

    always #50 sys_clk = ~sys_clk;

    // --------------------
    // random numbers
    // --------------------
    function automatic int take_bits(input int count);
        int r;
        r = 0;
        for (int i = 0; i < count; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = (r << 1) | lfsr[0];
        end
        return r;
    endfunction

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v > hi) return hi;
        if (v < lo) return lo;
        return v;
    endfunction

    // --------------------
    // reference model
    // --------------------
    function automatic void model_tick(input char_pkg::btn_t b);
        logic                  on_g;
        logic                  hit_sd;
        logic                  ftg;
        char_pkg::char_state_e nxt;
        int                    boost;
        int                    jx;
        int                    vx;
        int                    vy;
        int                    px;
        int                    py;
        on_g   = (m_py == char_pkg::FLOOR_Y);
        hit_sd = (m_px <= char_pkg::MIN_X) || (m_px >= char_pkg::MAX_X);
        ftg    = on_g && (m_vy < 0) && !m_prev_ground;
        if (b.jump && !m_btn.jump && on_g) m_armed = 1'b1;   // edge on ground only
        m_btn = b;

        nxt = char_pkg::IDLE;
        if (ftg) begin
            nxt = char_pkg::FALL_TO_GROUND;
        end else if (hit_sd) begin
            nxt = char_pkg::COLLISION;
        end else if (m_state inside {char_pkg::IDLE, char_pkg::LEFT, char_pkg::RIGHT}) begin
            if (on_g && b.left) nxt = char_pkg::LEFT;
            else if (on_g && b.right) nxt = char_pkg::RIGHT;
            else if (on_g && m_armed) nxt = char_pkg::CHARGE;
        end else if (m_state == char_pkg::CHARGE) begin
            nxt = (!b.jump || m_charge >= 500) ? char_pkg::JUMP : char_pkg::CHARGE;
        end

        // velocity from the state in force at this tick
        boost = 256 * ((m_charge / 64) % 8) + 64 * ((m_charge / 8) % 8) + 32
              + 32 * (m_charge % 8);
        jx = char_pkg::JUMP_VEL_X + (boost >>> 2) + (boost >>> 3);
        vx = m_vx;
        vy = m_vy;
        if (ftg) begin
            vx = 0;
            vy = 0;
        end else if (hit_sd) begin
            vx = -((m_vx >>> 1) + (m_vx >>> 2));
            if (!on_g) m_bounced = 1'b1;
        end else if (m_state == char_pkg::JUMP) begin
            vx = (m_face < 0) ? -jx : jx;
            vy = char_pkg::JUMP_VEL_Y + boost;
        end
        if (!on_g) vy = vy + char_pkg::GRAVITY;
        vx = clamp(vx, -char_pkg::MAX_VEL, char_pkg::MAX_VEL);
        vy = clamp(vy, -char_pkg::MAX_VEL, char_pkg::MAX_VEL);

        px = m_px + (vx >>> char_pkg::SMOOTH);
        if (m_state == char_pkg::LEFT) px = px + 1;
        if (m_state == char_pkg::RIGHT) px = px - 1;
        px = clamp(px, char_pkg::MIN_X, char_pkg::MAX_X);
        py = m_py + (vy >>> char_pkg::SMOOTH);
        if (py < char_pkg::FLOOR_Y) py = char_pkg::FLOOR_Y;

        if (m_state == char_pkg::CHARGE) m_charge = m_charge + 10;
        else if (m_state == char_pkg::JUMP) m_charge = 1;
        if (hit_sd) m_face = -m_face;
        else if (m_state == char_pkg::LEFT) m_face = 1;
        else if (m_state == char_pkg::RIGHT) m_face = -1;

        if (m_state == char_pkg::JUMP) m_armed = 1'b0;   // launch consumes it
        m_prev_ground = on_g;           // ground seen on this tick
        m_state = nxt;
        m_px = px;
        m_py = py;
        m_vx = vx;
        m_vy = vy;
    endfunction

    // --------------------
    // stimulus helpers
    // --------------------
    task automatic run_tick(input char_pkg::btn_t b);
        @(posedge sys_clk);
        btn       <= b;
        char_tick <= 1'b1;
        model_tick(b);
        @(posedge sys_clk);
        char_tick <= 1'b0;
        repeat (6) @(posedge sys_clk);
    endtask

    task automatic fly_until_landed(input char_pkg::btn_t b);
        int k;
        k = 0;
        run_tick(b);
        while (!(m_state == char_pkg::IDLE && m_vy == 0 && m_py == char_pkg::FLOOR_Y)
               && k < 100) begin
            run_tick(b);
            k++;
        end
        if (k >= 100) begin
            $display("character did not land within 100 ticks");
            errors++;
        end
    endtask

    task automatic check_val(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // compare 3 cycles into every tick
    always @(posedge sys_clk) begin
        if (char_tick) tick_age <= 1;
        else if (tick_age != 0 && tick_age < 4) tick_age <= tick_age + 1;
        if (sys_rst_n && tick_age == 3) begin
            check_val("kin.pos_x", m_px, int'(kin.pos_x));
            check_val("kin.pos_y", m_py, int'(kin.pos_y));
            check_val("kin.vel_x", m_vx, int'(kin.vel_x));
            check_val("kin.vel_y", m_vy, int'(kin.vel_y));
            check_val("face", int'(m_face), int'(face));
            check_val("charge_level", m_charge, int'(charge_level));
            check_val("state", int'(m_state), int'(state));
        end
    end

    always @(posedge sys_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        sys_clk = 1'b0;
        sys_rst_n = 1'b0;
        btn = '0;
        char_tick = 1'b0;
        lfsr = 16'd79;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        err_mark = 0;
        cycles = 0;
        tick_age = 0;
        m_state = char_pkg::IDLE;
        m_face = 1;
        m_charge = 1;
        m_px = char_pkg::INIT_X;
        m_py = char_pkg::INIT_Y;
        m_vx = 0;
        m_vy = 0;
        m_prev_ground = 1'b1;
        m_armed = 1'b0;
        m_bounced = 1'b0;
        m_btn = '0;
        repeat (16) @(posedge sys_clk);
        sys_rst_n <= 1'b1;

        // reset values hold with no tick
        repeat (5) begin
            @(posedge sys_clk);
            check_val("kin.pos_x", char_pkg::INIT_X, int'(kin.pos_x));
            check_val("kin.pos_y", char_pkg::INIT_Y, int'(kin.pos_y));
            check_val("kin.vel_x", 0, int'(kin.vel_x));
            check_val("kin.vel_y", 0, int'(kin.vel_y));
            check_val("face", 1, int'(face));
            check_val("charge_level", 1, int'(charge_level));
            check_val("state", int'(char_pkg::IDLE), int'(state));
        end
        end_test("reset");

        n = take_bits(5);
        if (n == 0) n = 1;
        repeat (n) run_tick('{left: 1'b1, default: 1'b0});
        repeat (2) run_tick('0);
        end_test("walk left");

        n = take_bits(4);
        if (n == 0) n = 1;
        repeat (n) run_tick('{jump: 1'b1, default: 1'b0});
        run_tick('0);           // release, state goes to JUMP
        run_tick('0);           // launch
        end_test("charge and launch");

        fly_until_landed('0);
        end_test("flight and landing");

        repeat (40) run_tick('{left: 1'b1, default: 1'b0});
        run_tick('0);
        repeat (15) run_tick('{jump: 1'b1, default: 1'b0});
        run_tick('0);
        fly_until_landed('0);
        if (!m_bounced) begin
            $display("jump toward the wall never reached it");
            errors++;
        end
        end_test("side bounce");

        repeat (3) run_tick('{jump: 1'b1, default: 1'b0});
        repeat (3) run_tick('0);
        // press in the air and keep holding through the landing
        fly_until_landed('{jump: 1'b1, default: 1'b0});
        repeat (3) begin
            run_tick('{jump: 1'b1, default: 1'b0});
            if (state == char_pkg::CHARGE) begin
                $display("airborne jump press led to a charge");
                errors++;
            end
        end
        run_tick('0);
        repeat (2) run_tick('{jump: 1'b1, default: 1'b0});
        if (state != char_pkg::CHARGE) begin
            $display("new jump press on the ground did not start a charge");
            errors++;
        end
        run_tick('0);
        fly_until_landed('0);
        end_test("airborne jump ignored");

        repeat (300) run_tick('{right: 1'b1, default: 1'b0});
        check_val("kin.pos_x", char_pkg::MIN_X, int'(kin.pos_x));
        end_test("walk right to wall");

        $display("%0d tests passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* test/char_assert.sv */
`timescale 1ns/1ps

module char_assert (
    input logic           sys_clk,
    input logic           sys_rst_n,
    input logic           tick_q,
    input char_pkg::kin_t kin,
    input logic [15:0]    charge_level
);

    // --------------------
    // arena and speed limits
    // --------------------
    floor_limit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        kin.pos_y >= char_pkg::FLOOR_Y)
        else $error("pos_y below floor");

    side_limit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        kin.pos_x >= char_pkg::MIN_X && kin.pos_x <= char_pkg::MAX_X)
        else $error("pos_x outside walls");

    vel_limit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        kin.vel_x <= char_pkg::MAX_VEL && kin.vel_x >= -char_pkg::MAX_VEL &&
        kin.vel_y <= char_pkg::MAX_VEL && kin.vel_y >= -char_pkg::MAX_VEL)
        else $error("velocity over limit");

    // charge only moves on the tick edge
    charge_on_tick: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $changed(charge_level) |-> $past(tick_q))
        else $error("charge_level changed without a tick");

endmodule

bind char_top char_assert u_char_assert (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .tick_q       (tick_q),
    .kin          (kin),
    .charge_level (charge_level)
);

/* rtl/char_top.sv */
`timescale 1ns/1ps

module char_top (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  char_pkg::btn_t        btn,
    input  logic                  char_tick,
    output char_pkg::kin_t        kin,
    output char_pkg::char_state_e state,
    output logic signed [1:0]     face,
    output logic [15:0]           charge_level
);

    char_pkg::btn_t     btn_q;
    char_pkg::contact_t contact;
    logic               tick_q;
    logic               jump_armed;
    logic               in_jump;

    assign in_jump = (state == char_pkg::JUMP);    // clears the armed jump

    input_sampler u_input_sampler (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .btn        (btn),
        .char_tick  (char_tick),
        .on_ground  (contact.on_ground),
        .in_jump    (in_jump),
        .btn_q      (btn_q),
        .tick_q     (tick_q),
        .jump_armed (jump_armed)
    );

    wall_detect u_wall_detect (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .kin       (kin),
        .contact   (contact)
    );

    char_fsm u_char_fsm (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .tick_q       (tick_q),
        .btn_q        (btn_q),
        .jump_armed   (jump_armed),
        .contact      (contact),
        .state        (state),
        .face         (face),
        .charge_level (charge_level)
    );

    char_physics u_char_physics (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .tick_q       (tick_q),
        .state        (state),
        .face         (face),
        .charge_level (charge_level),
        .contact      (contact),
        .kin          (kin)
    );

endmodule

/* rtl/char_physics.sv */
`timescale 1ns/1ps

module char_physics (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  tick_q,
    input  char_pkg::char_state_e state,
    input  logic signed [1:0]     face,
    input  logic [15:0]           charge_level,
    input  char_pkg::contact_t    contact,
    output char_pkg::kin_t        kin
);

    char_pkg::phys_t boost;
    char_pkg::phys_t jump_x;
    char_pkg::phys_t vx;
    char_pkg::phys_t vy;
    char_pkg::phys_t vx_n;
    char_pkg::phys_t vy_n;
    char_pkg::phys_t step;
    char_pkg::phys_t px;
    char_pkg::phys_t py;

    function automatic char_pkg::phys_t clamp_vel(input char_pkg::phys_t v);
        if (v > char_pkg::MAX_VEL) begin
            return char_pkg::MAX_VEL;
        end else if (v < -char_pkg::MAX_VEL) begin
            return -char_pkg::MAX_VEL;
        end
        return v;
    endfunction

    // --------------------
    // velocity
    // --------------------
    always_comb begin
        // octal digits of the charge, 256*d2 + 64*d1 + 32 + 32*d0
        boost = {6'b0, charge_level[8:6], 8'b0}
              + {8'b0, charge_level[5:3], 6'b100000}
              + {9'b0, charge_level[2:0], 5'b0};
        jump_x = char_pkg::JUMP_VEL_X + (boost >>> 2) + (boost >>> 3);

        vx = kin.vel_x;
        vy = kin.vel_y;
        if (contact.fall_to_ground) begin
            vx = '0;
            vy = '0;
        end else if (contact.hit_side) begin
            vx = -((kin.vel_x >>> 1) + (kin.vel_x >>> 2));    // 3/4 back
        end else if (state == char_pkg::JUMP) begin
            vx = (face < 0) ? -jump_x : jump_x;
            vy = char_pkg::JUMP_VEL_Y + boost;
        end

        if (!contact.on_ground) begin
            vy = vy + char_pkg::GRAVITY;
        end

        vx_n = clamp_vel(vx);
        vy_n = clamp_vel(vy);
    end

    // --------------------
    // position
    // --------------------
    always_comb begin
        case (state)
            char_pkg::LEFT:  step = char_pkg::phys_t'(1);
            char_pkg::RIGHT: step = -char_pkg::phys_t'(1);
            default:         step = '0;
        endcase

        px = kin.pos_x + step + (vx_n >>> char_pkg::SMOOTH);
        py = kin.pos_y + (vy_n >>> char_pkg::SMOOTH);

        if (px > char_pkg::MAX_X) begin
            px = char_pkg::MAX_X;
        end else if (px < char_pkg::MIN_X) begin
            px = char_pkg::MIN_X;
        end
        if (py < char_pkg::FLOOR_Y) begin
            py = char_pkg::FLOOR_Y;     // never sink into the floor
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            kin.pos_x <= char_pkg::INIT_X;
            kin.pos_y <= char_pkg::INIT_Y;
            kin.vel_x <= '0;
            kin.vel_y <= '0;
        end else if (tick_q) begin
            kin.pos_x <= px;
            kin.pos_y <= py;
            kin.vel_x <= vx_n;
            kin.vel_y <= vy_n;
        end
    end

endmodule

/* rtl/char_fsm.sv */
`timescale 1ns/1ps

module char_fsm (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  logic                  tick_q,
    input  char_pkg::btn_t        btn_q,
    input  logic                  jump_armed,
    input  char_pkg::contact_t    contact,
    output char_pkg::char_state_e state,
    output logic signed [1:0]     face,
    output logic [15:0]           charge_level
);

    char_pkg::char_state_e next_state;
    logic                  max_charge;

    assign max_charge = (charge_level >= char_pkg::MAX_CHARGE);

    // --------------------
    // next state
    // --------------------
    // contacts win over anything the buttons ask for
    always_comb begin
        next_state = char_pkg::IDLE;
        if (contact.fall_to_ground) begin
            next_state = char_pkg::FALL_TO_GROUND;
        end else if (contact.hit_side) begin
            next_state = char_pkg::COLLISION;
        end else begin
            case (state)
                char_pkg::IDLE, char_pkg::LEFT, char_pkg::RIGHT: begin
                    if (contact.on_ground) begin
                        if (btn_q.left) begin
                            next_state = char_pkg::LEFT;
                        end else if (btn_q.right) begin
                            next_state = char_pkg::RIGHT;
                        end else if (jump_armed) begin
                            next_state = char_pkg::CHARGE;
                        end else begin
                            next_state = char_pkg::IDLE;
                        end
                    end
                end
                char_pkg::CHARGE: begin
                    // release or full charge launches
                    if (!btn_q.jump || max_charge) begin
                        next_state = char_pkg::JUMP;
                    end else begin
                        next_state = char_pkg::CHARGE;
                    end
                end
                default: begin
                    next_state = char_pkg::IDLE;   // jump, collision, landing
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= char_pkg::IDLE;
        end else if (tick_q) begin
            state <= next_state;
        end
    end

    // --------------------
    // charge and facing
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            charge_level <= 16'd1;
            face         <= 2'sd1;
        end else if (tick_q) begin
            if (state == char_pkg::CHARGE) begin
                charge_level <= charge_level + char_pkg::CHARGE_STEP;
            end else if (state == char_pkg::JUMP) begin
                charge_level <= 16'd1;
            end

            if (contact.hit_side) begin
                face <= -face;          // turn around off the wall
            end else if (state == char_pkg::LEFT) begin
                face <= 2'sd1;
            end else if (state == char_pkg::RIGHT) begin
                face <= -2'sd1;
            end
        end
    end

endmodule

/* rtl/wall_detect.sv */
`timescale 1ns/1ps

module wall_detect (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  char_pkg::kin_t     kin,
    output char_pkg::contact_t contact
);

    char_pkg::phys_t last_y;        // pos_y seen on the previous cycle
    logic            prev_ground;   // ground bit from before the latest move

    logic ground_now;
    logic moving_down;
    logic moved;
    logic ground_before;

    always_comb begin
        ground_now  = (kin.pos_y == char_pkg::FLOOR_Y);
        moving_down = (kin.vel_y < 0);
        moved       = (kin.pos_y != last_y);

        // kin only moves on a tick, so a change marks the tick boundary
        ground_before = moved ? (last_y == char_pkg::FLOOR_Y) : prev_ground;
    end

    // --------------------
    // tracking
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            last_y      <= char_pkg::INIT_Y;
            prev_ground <= 1'b1;    // starts standing
        end else begin
            last_y      <= kin.pos_y;
            prev_ground <= ground_before;
        end
    end

    // --------------------
    // contact register
    // --------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            contact <= '{on_ground: 1'b1, default: 1'b0};
        end else begin
            contact.on_ground      <= ground_now;
            contact.hit_floor      <= ground_now && moving_down;
            contact.hit_side       <= (kin.pos_x <= char_pkg::MIN_X) ||
                                      (kin.pos_x >= char_pkg::MAX_X);
            contact.fall_to_ground <= ground_now && moving_down && !ground_before;
        end
    end

endmodule

/* rtl/input_sampler.sv */
`timescale 1ns/1ps

module input_sampler (
    input  logic           sys_clk,
    input  logic           sys_rst_n,
    input  char_pkg::btn_t btn,
    input  logic           char_tick,
    input  logic           on_ground,
    input  logic           in_jump,
    output char_pkg::btn_t btn_q,
    output logic           tick_q,
    output logic           jump_armed
);

    logic jump_edge;

    // rising edge against the registered copy
    assign jump_edge = btn.jump & ~btn_q.jump;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            btn_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            btn_q  <= btn;
            tick_q <= char_tick;    // all motion steps on this delayed strobe
        end
    end

    // --------------------
    // jump edge latch
    // --------------------
    // an edge only counts while standing, airborne presses are dropped
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            jump_armed <= 1'b0;
        end else if (jump_edge && on_ground) begin
            jump_armed <= 1'b1;
        end else if (in_jump) begin
            jump_armed <= 1'b0;     // consumed by the launch
        end
    end

endmodule

/* rtl/char_pkg.sv */
package char_pkg;

    // fixed-point format
    localparam int PHY_W  = 17;
    localparam int SMOOTH = 8;              // fraction bits, vel in 1/256 px per tick

    typedef logic signed [PHY_W-1:0] phys_t;

    // --------------------
    // arena limits
    // --------------------
    localparam phys_t FLOOR_Y = phys_t'(20);   // wall height
    localparam phys_t MIN_X   = phys_t'(160);
    localparam phys_t MAX_X   = phys_t'(518);  // left wall 560 minus char width 42

    // --------------------
    // motion constants
    // --------------------
    localparam phys_t MAX_VEL    = phys_t'(58) <<< SMOOTH;
    localparam phys_t GRAVITY    = -(phys_t'(1) <<< SMOOTH);
    localparam phys_t JUMP_VEL_X = phys_t'(2) <<< SMOOTH;
    localparam phys_t JUMP_VEL_Y = phys_t'(6) <<< SMOOTH;

    // jump charge
    localparam logic [15:0] MAX_CHARGE  = 16'd500;
    localparam logic [15:0] CHARGE_STEP = 16'd10;

    // start position, standing on the floor
    localparam phys_t INIT_X = phys_t'(430);
    localparam phys_t INIT_Y = FLOOR_Y;

    // --------------------
    // types
    // --------------------
    typedef enum logic [2:0] {
        IDLE           = 3'd0,
        LEFT           = 3'd1,
        RIGHT          = 3'd2,
        CHARGE         = 3'd3,
        JUMP           = 3'd4,
        COLLISION      = 3'd5,
        FALL_TO_GROUND = 3'd6
    } char_state_e;

    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } btn_t;

    // character kinematics, all signed fixed width
    typedef struct packed {
        phys_t pos_x;
        phys_t pos_y;
        phys_t vel_x;
        phys_t vel_y;
    } kin_t;

    typedef struct packed {
        logic on_ground;        // resting on the floor line
        logic hit_floor;        // on floor and still moving down
        logic hit_side;         // against either side wall
        logic fall_to_ground;   // landing, was airborne before
    } contact_t;

endpackage
